// ==== bench/core_tb_program.svh ====
localparam int PROG_LEN     = 32;
localparam int ACCESS_COUNT = 9;

// Program rows are {opcode, rd, rn, rm, shift, shift amount, imm select, imm8}.
word_t program_words [PROG_LEN] = '{
        {OP_MOV, 4'd1, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b1, 8'hC5},        // r1 = 0x1C5.
        {OP_ADD, 4'd2, 4'd1, 4'd1, SH_LSL, 5'd0, 1'b0, 8'h00},
        {OP_SUB, 4'd3, 4'd2, 4'd1, SH_LSR, 5'd1, 1'b0, 8'h00},        // 0x38A - 0xE2.
        {OP_AND, 4'd4, 4'd3, 4'd2, SH_LSL, 5'd0, 1'b0, 8'h00},
        {OP_ORR, 4'd5, 4'd4, 4'd1, SH_LSL, 5'd0, 1'b0, 8'h00},
        {OP_EOR, 4'd6, 4'd5, 4'd3, SH_LSL, 5'd0, 1'b0, 8'h00},        // r3 from writeback.
        {OP_MOV, 4'd7, 4'd0, 4'd6, SH_LSL, 5'd4, 1'b0, 8'h00},
        {OP_STR, 4'd7, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h04},
        {OP_STR, 4'd5, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h08},
        {OP_STR, 4'd3, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h0C},
        {OP_MOV, 4'd8, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b1, 8'h81},        // r8 = 0x181.
        {OP_MOV, 4'd9, 4'd0, 4'd8, SH_ROR, 5'd1, 1'b0, 8'h00},        // r9 = 0x800000C0.
        {OP_MOV, 4'd10, 4'd0, 4'd9, SH_LSL, 5'd0, 1'b0, 8'h00},
        {OP_ADD, 4'd10, 4'd10, 4'd9, SH_LSL, 5'd1, 1'b0, 8'h00},
        {OP_ADD, 4'd10, 4'd10, 4'd8, SH_LSL, 5'd31, 1'b0, 8'h00},
        {OP_ADD, 4'd10, 4'd10, 4'd9, SH_LSR, 5'd0, 1'b0, 8'h00},
        {OP_ADD, 4'd10, 4'd10, 4'd9, SH_LSR, 5'd1, 1'b0, 8'h00},
        {OP_ADD, 4'd10, 4'd10, 4'd9, SH_LSR, 5'd31, 1'b0, 8'h00},
        {OP_MOV, 4'd11, 4'd0, 4'd9, SH_ASR, 5'd0, 1'b0, 8'h00},
        {OP_EOR, 4'd11, 4'd11, 4'd9, SH_ASR, 5'd1, 1'b0, 8'h00},
        {OP_ADD, 4'd11, 4'd11, 4'd9, SH_ASR, 5'd31, 1'b0, 8'h00},
        {OP_ADD, 4'd11, 4'd11, 4'd9, SH_ROR, 5'd0, 1'b0, 8'h00},
        {OP_ADD, 4'd11, 4'd11, 4'd8, SH_ROR, 5'd1, 1'b0, 8'h00},
        {OP_ADD, 4'd11, 4'd11, 4'd9, SH_ROR, 5'd31, 1'b0, 8'h00},
        {OP_STR, 4'd10, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h20},
        {OP_STR, 4'd11, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h24},
        {OP_LDR, 4'd12, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h30},
        {OP_ADD, 4'd13, 4'd12, 4'd0, SH_LSL, 5'd0, 1'b1, 8'h0F},      // Two-cycle load-use.
        {OP_STR, 4'd13, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h34},
        {OP_LDR, 4'd14, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h38},
        {OP_MOV, 4'd15, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b1, 8'h42},
        {OP_STR, 4'd14, 4'd0, 4'd0, SH_LSL, 5'd0, 1'b0, 8'h3C}        // One-cycle load-use.
};

// Access rows are {read_en, write_en, address, store data} in completion order.
dmem_req_t expected_access [ACCESS_COUNT] = '{
        {1'b0, 1'b1, 32'h0000_0004, 32'h0000_1650},
        {1'b0, 1'b1, 32'h0000_0008, 32'h0000_03CD},
        {1'b0, 1'b1, 32'h0000_000C, 32'h0000_02A8},
        {1'b0, 1'b1, 32'h0000_0020, 32'hC000_0361},   // LSL and LSR sum.
        {1'b0, 1'b1, 32'h0000_0024, 32'h4000_03A0},   // ASR and ROR mix.
        {1'b1, 1'b0, 32'h0000_0030, 32'h0000_0000},
        {1'b0, 1'b1, 32'h0000_0034, 32'hA5A5_013F},
        {1'b1, 1'b0, 32'h0000_0038, 32'h0000_0000},
        {1'b0, 1'b1, 32'h0000_003C, 32'hA5A5_0038}
};

// ==== bench/core_tb.sv ====
module core_tb import core_pkg::*; ();

        timeunit 1ns;
        timeprecision 100ps;

        `include "core_tb_program.svh"

        localparam int    RUN_LIMIT = 8 * PROG_LEN + 200;
        localparam int    DRAIN     = 16;
        localparam word_t LOAD_MASK = 32'hA5A5_0000;

        logic      i_clk = 1'b0;
        logic      i_arst_n;
        word_t     i_instruction;
        logic      i_valid;
        logic      i_data_stall;
        word_t     i_rd_data;
        word_t     o_pc;
        dmem_req_t o_dmem;

        integer    seed = 11044;
        int        errors;
        int        access_idx;
        int        cycles;
        bit        run_active;
        bit        gaps;
        bit        timed_out;
        bit        run_gaps [2] = '{1'b0, 1'b1};

        core_top core_top_inst (.*);

        always #4 i_clk = ~i_clk;

        function automatic word_t fetch_word(word_t pc);
                if ((pc >> 2) < PROG_LEN) begin
                        return program_words[pc >> 2];
                end
                return {OP_NOP, 28'd0};         // Past the end of the program.
        endfunction

        task automatic check_word(string name, word_t got, word_t exp);
                if (got !== exp) begin
                        $display("FAIL %0d ns %s: got %h, expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_req(string name, dmem_req_t got, dmem_req_t exp);
                if (got !== exp) begin
                        $display("FAIL %0d ns %s: got %h, expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        // Instruction and data side models.
        always @(posedge i_clk) begin
                #1;
                i_instruction = fetch_word(o_pc);
                i_valid       = run_active && (!gaps || ($random(seed) & 3) != 0);
                i_data_stall  = gaps && (o_dmem.read_en || o_dmem.write_en) &&
                                (($random(seed) & 3) == 0);
                i_rd_data     = o_dmem.address ^ LOAD_MASK;
        end

        // An access completes on a cycle without data stall.
        always @(negedge i_clk) begin : access_monitor
                dmem_req_t got;
                if (i_arst_n && !i_data_stall && (o_dmem.read_en || o_dmem.write_en)) begin
                        if (access_idx < ACCESS_COUNT) begin
                                got = o_dmem;
                                if (expected_access[access_idx].read_en) begin
                                        got.wr_data = '0;       // Don't care on a load.
                                end
                                check_req("o_dmem", got, expected_access[access_idx]);
                        end else begin
                                $display("Extra memory access at %0d ns to address %h",
                                         $time, o_dmem.address);
                                errors++;
                        end
                        access_idx++;
                end
        end

        initial begin
                errors        = 0;
                access_idx    = 0;
                run_active    = 1'b0;
                gaps          = 1'b0;
                timed_out     = 1'b0;
                i_arst_n      = 1'b0;
                i_instruction = '0;
                i_valid       = 1'b0;
                i_data_stall  = 1'b0;
                i_rd_data     = '0;
                for (int run = 0; run < 2 && !timed_out; run++) begin
                        @(posedge i_clk);
                        #1;
                        run_active = 1'b0;
                        gaps       = run_gaps[run];
                        i_arst_n   = 1'b0;
                        access_idx = 0;
                        repeat (4) begin
                                @(negedge i_clk);
                                check_word("o_pc", o_pc, RESET_PC);
                                check_req("o_dmem", o_dmem, '0);
                        end
                        @(posedge i_clk);
                        #1;
                        i_arst_n = 1'b1;
                        @(negedge i_clk);
                        check_word("o_pc", o_pc, RESET_PC);     // Nothing fetched yet.
                        check_req("o_dmem", o_dmem, '0);
                        run_active = 1'b1;
                        cycles     = 0;
                        while (access_idx < ACCESS_COUNT && cycles < RUN_LIMIT) begin
                                @(posedge i_clk);
                                cycles++;
                        end
                        if (access_idx < ACCESS_COUNT) begin
                                $display("Run %0d timed out with %0d of %0d accesses seen",
                                         run, access_idx, ACCESS_COUNT);
                                errors++;
                                timed_out = 1'b1;
                        end else begin
                                repeat (DRAIN) @(posedge i_clk);
                        end
                end
                $display("Errors: %0d", errors);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

// ==== core_top.f ====
logic/core_pkg.sv
logic/core_fetch.sv
logic/core_decode.sv
logic/core_regfile.sv
logic/core_issue.sv
logic/core_execute.sv
logic/core_memory.sv
logic/core_top.sv
+incdir+bench
bench/core_tb.sv

// ==== logic/core_decode.sv ====
module core_decode import core_pkg::*; (
        input  logic    i_clk,
        input  logic    i_arst_n,
        input  logic    i_stall,
        input  word_t   i_instr,
        input  logic    i_instr_valid,
        output uop_t    o_uop
);

        opcode_e op_field;
        logic    known_op;
        logic    mem_op;
        uop_t    uop_nxt;

        assign op_field = opcode_e'(i_instr[31:28]);

        always_comb begin
                case (op_field)
                OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_ORR,
                OP_EOR, OP_MOV, OP_LDR, OP_STR: known_op = 1'b1;
                default:                        known_op = 1'b0;
                endcase
        end

        assign mem_op = known_op && (op_field == OP_LDR || op_field == OP_STR);

        always_comb begin
                uop_nxt.opcode  = known_op ? op_field : OP_NOP;
                uop_nxt.rd      = i_instr[27:24];
                uop_nxt.rn      = i_instr[23:20];
                uop_nxt.rm      = i_instr[19:16];
                uop_nxt.shift   = shift_e'(i_instr[15:14]);
                uop_nxt.shamt   = i_instr[13:9];
                uop_nxt.imm_sel = i_instr[8] || mem_op;   // Loads and stores use imm12.
                uop_nxt.imm12   = i_instr[11:0];

                // MOV has no rn, LDR/STR no rm, only STR reads rd.
                uop_nxt.use_rn  = known_op && op_field != OP_NOP && op_field != OP_MOV;
                uop_nxt.use_rm  = known_op && op_field != OP_NOP && !uop_nxt.imm_sel;
                uop_nxt.use_rd  = known_op && op_field == OP_STR;
                uop_nxt.valid   = i_instr_valid && known_op;
        end

        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_uop <= '0;
                end else if (!i_stall) begin
                        o_uop <= uop_nxt;
                end
        end

endmodule

// ==== logic/core_execute.sv ====
module core_execute import core_pkg::*; (
        input  logic      i_clk,
        input  logic      i_arst_n,
        input  logic      i_data_stall,
        input  issued_t   i_issued,
        output exec_t     o_exec_nxt,
        output exec_t     o_exec_ff,
        output dmem_req_t o_dmem
);

        logic [2*XLEN-1:0] rot_wide;
        word_t             shifted;
        word_t             op2;
        word_t             alu_out;
        dmem_req_t         dmem_nxt;

        assign rot_wide = {i_issued.op2_raw, i_issued.op2_raw} >> i_issued.shamt;

        always_comb begin
                case (i_issued.shift)
                SH_LSL:  shifted = i_issued.op2_raw << i_issued.shamt;
                SH_LSR:  shifted = i_issued.op2_raw >> i_issued.shamt;
                SH_ASR:  shifted = $signed(i_issued.op2_raw) >>> i_issued.shamt;
                SH_ROR:  shifted = rot_wide[XLEN-1:0];
                default: shifted = i_issued.op2_raw;
                endcase
        end

        assign op2 = i_issued.imm_sel ? i_issued.op2_raw : shifted;

        always_comb begin
                case (i_issued.opcode)
                OP_ADD:         alu_out = i_issued.op1 + op2;
                OP_SUB:         alu_out = i_issued.op1 - op2;
                OP_AND:         alu_out = i_issued.op1 & op2;
                OP_ORR:         alu_out = i_issued.op1 | op2;
                OP_EOR:         alu_out = i_issued.op1 ^ op2;
                OP_MOV:         alu_out = op2;
                OP_LDR, OP_STR: alu_out = i_issued.op1 + op2;   // Base plus offset.
                default:        alu_out = '0;
                endcase
        end

        always_comb begin
                o_exec_nxt.rd       = i_issued.rd;
                o_exec_nxt.result   = alu_out;
                o_exec_nxt.load     = i_issued.valid && i_issued.opcode == OP_LDR;
                o_exec_nxt.wb_valid = i_issued.valid && i_issued.opcode != OP_NOP &&
                                      i_issued.opcode != OP_STR;

                dmem_nxt.read_en    = o_exec_nxt.load;
                dmem_nxt.write_en   = i_issued.valid && i_issued.opcode == OP_STR;
                dmem_nxt.address    = alu_out;
                dmem_nxt.wr_data    = i_issued.store;
        end

        // Request stays put while the data side stalls.
        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_exec_ff <= '0;
                        o_dmem    <= '0;
                end else if (!i_data_stall) begin
                        o_exec_ff <= o_exec_nxt;
                        o_dmem    <= dmem_nxt;
                end
        end

        a_one_access: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                !(o_dmem.read_en && o_dmem.write_en));

endmodule

// ==== logic/core_fetch.sv ====
module core_fetch import core_pkg::*; (
        input  logic    i_clk,
        input  logic    i_arst_n,
        input  logic    i_stall,
        input  word_t   i_instruction,
        input  logic    i_valid,
        output word_t   o_pc,
        output word_t   o_instr,
        output logic    o_instr_valid
);

        logic accept;

        assign accept = i_valid && !i_stall;

        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_pc          <= RESET_PC;
                        o_instr_valid <= 1'b0;
                end else if (!i_stall) begin
                        o_instr_valid <= i_valid;
                        if (i_valid) begin
                                o_pc <= o_pc + 32'd4;   // Next word.
                        end
                end
        end

        always_ff @(posedge i_clk) begin
                if (accept) begin
                        o_instr <= i_instruction;
                end
        end

        // PC may only move on an accepted word.
        a_pc_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_stall |=> $stable(o_pc));

endmodule

// ==== logic/core_issue.sv ====
module core_issue import core_pkg::*; (
        input  logic    i_clk,
        input  logic    i_arst_n,
        input  logic    i_data_stall,
        input  uop_t    i_uop,
        input  exec_t   i_exec_nxt,
        input  exec_t   i_exec_ff,
        input  wb_t     i_wb,
        output logic    o_load_stall,
        output issued_t o_issued
);

        word_t   rn_rf;
        word_t   rm_rf;
        word_t   rd_rf;
        word_t   rn_val;
        word_t   rm_val;
        word_t   rd_val;
        issued_t issued_nxt;

        core_regfile u_core_regfile (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_wb           (i_wb),
                .i_rd_idx_a     (i_uop.rn),
                .i_rd_idx_b     (i_uop.rm),
                .i_rd_idx_c     (i_uop.rd),
                .o_rd_data_a    (rn_rf),
                .o_rd_data_b    (rm_rf),
                .o_rd_data_c    (rd_rf)
        );

        // Nearest writer wins.
        function automatic word_t fwd_value(reg_idx_t idx, word_t rf_data,
                                            exec_t nxt, exec_t ff);
                if (nxt.wb_valid && nxt.rd == idx) begin
                        return nxt.result;
                end
                if (ff.wb_valid && ff.rd == idx) begin
                        return ff.result;
                end
                return rf_data;
        endfunction

        function automatic logic load_pending(reg_idx_t idx, logic used,
                                              exec_t nxt, exec_t ff);
                return used && ((nxt.load && nxt.rd == idx) || (ff.load && ff.rd == idx));
        endfunction

        assign rn_val = fwd_value(i_uop.rn, rn_rf, i_exec_nxt, i_exec_ff);
        assign rm_val = fwd_value(i_uop.rm, rm_rf, i_exec_nxt, i_exec_ff);
        assign rd_val = fwd_value(i_uop.rd, rd_rf, i_exec_nxt, i_exec_ff);

        assign o_load_stall = i_uop.valid &&
                (load_pending(i_uop.rn, i_uop.use_rn, i_exec_nxt, i_exec_ff) ||
                 load_pending(i_uop.rm, i_uop.use_rm, i_exec_nxt, i_exec_ff) ||
                 load_pending(i_uop.rd, i_uop.use_rd, i_exec_nxt, i_exec_ff));

        always_comb begin
                issued_nxt.opcode  = i_uop.opcode;
                issued_nxt.rd      = i_uop.rd;
                issued_nxt.valid   = i_uop.valid && !o_load_stall;   // Bubble on load-use.
                issued_nxt.op1     = rn_val;
                issued_nxt.op2_raw = i_uop.imm_sel ? {{(XLEN-IMM_W){1'b0}}, i_uop.imm12}
                                                   : rm_val;
                issued_nxt.store   = rd_val;
                issued_nxt.shift   = i_uop.shift;
                issued_nxt.shamt   = i_uop.shamt;
                issued_nxt.imm_sel = i_uop.imm_sel;
        end

        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_issued <= '0;
                end else if (!i_data_stall) begin
                        o_issued <= issued_nxt;
                end
        end

        a_no_issue_on_load_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_load_stall && !i_data_stall |=> !o_issued.valid);

endmodule

// ==== logic/core_memory.sv ====
module core_memory import core_pkg::*; (
        input  logic    i_clk,
        input  logic    i_arst_n,
        input  logic    i_data_stall,
        input  exec_t   i_exec,
        input  word_t   i_rd_data,
        output wb_t     o_wb
);

        wb_t wb_nxt;

        always_comb begin
                wb_nxt.wen  = i_exec.wb_valid;  // Clear for stores and bubbles.
                wb_nxt.idx  = i_exec.rd;
                wb_nxt.data = i_exec.load ? i_rd_data : i_exec.result;
        end

        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_wb <= '0;
                end else if (!i_data_stall) begin
                        o_wb <= wb_nxt;
                end
        end

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

        localparam int XLEN      = 32;
        localparam int REG_COUNT = 16;
        localparam int REG_IDX_W = 4;
        localparam int SHAMT_W   = 5;
        localparam int IMM_W     = 12;

        typedef logic [XLEN-1:0]      word_t;
        typedef logic [REG_IDX_W-1:0] reg_idx_t;

        localparam word_t RESET_PC = '0;

        typedef enum logic [3:0] {
                OP_NOP = 4'd0,
                OP_ADD = 4'd1,
                OP_SUB = 4'd2,
                OP_AND = 4'd3,
                OP_ORR = 4'd4,
                OP_EOR = 4'd5,
                OP_MOV = 4'd6,
                OP_LDR = 4'd7,
                OP_STR = 4'd8
        } opcode_e;

        typedef enum logic [1:0] {
                SH_LSL = 2'd0,
                SH_LSR = 2'd1,
                SH_ASR = 2'd2,
                SH_ROR = 2'd3
        } shift_e;

        // Decoded micro-op.
        typedef struct packed {
                opcode_e                opcode;
                reg_idx_t               rd;
                reg_idx_t               rn;
                reg_idx_t               rm;
                shift_e                 shift;
                logic [SHAMT_W-1:0]     shamt;
                logic                   imm_sel;
                logic [IMM_W-1:0]       imm12;
                logic                   use_rn;
                logic                   use_rm;
                logic                   use_rd;         // Store data source.
                logic                   valid;
        } uop_t;

        typedef struct packed {
                opcode_e                opcode;
                reg_idx_t               rd;
                logic                   valid;
                word_t                  op1;
                word_t                  op2_raw;        // Rm value or imm12.
                word_t                  store;
                shift_e                 shift;
                logic [SHAMT_W-1:0]     shamt;
                logic                   imm_sel;
        } issued_t;

        typedef struct packed {
                reg_idx_t               rd;
                word_t                  result;
                logic                   load;
                logic                   wb_valid;
        } exec_t;

        typedef struct packed {
                logic                   read_en;
                logic                   write_en;
                word_t                  address;
                word_t                  wr_data;
        } dmem_req_t;

        typedef struct packed {
                logic                   wen;
                reg_idx_t               idx;
                word_t                  data;
        } wb_t;

endpackage

// ==== logic/core_regfile.sv ====
module core_regfile import core_pkg::*; (
        input  logic     i_clk,
        input  logic     i_arst_n,
        input  wb_t      i_wb,
        input  reg_idx_t i_rd_idx_a,
        input  reg_idx_t i_rd_idx_b,
        input  reg_idx_t i_rd_idx_c,
        output word_t    o_rd_data_a,
        output word_t    o_rd_data_b,
        output word_t    o_rd_data_c
);

        word_t regs [REG_COUNT];

        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        for (int i = 0; i < REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_wb.wen) begin
                        regs[i_wb.idx] <= i_wb.data;
                end
        end

        // Write-through on a same-cycle write.
        assign o_rd_data_a = (i_wb.wen && i_wb.idx == i_rd_idx_a) ? i_wb.data
                                                                 : regs[i_rd_idx_a];
        assign o_rd_data_b = (i_wb.wen && i_wb.idx == i_rd_idx_b) ? i_wb.data
                                                                 : regs[i_rd_idx_b];
        assign o_rd_data_c = (i_wb.wen && i_wb.idx == i_rd_idx_c) ? i_wb.data
                                                                 : regs[i_rd_idx_c];

endmodule

// ==== logic/core_top.sv ====
module core_top import core_pkg::*; (
        input  logic      i_clk,
        input  logic      i_arst_n,
        input  word_t     i_instruction,
        input  logic      i_valid,
        input  logic      i_data_stall,
        input  word_t     i_rd_data,
        output word_t     o_pc,
        output dmem_req_t o_dmem
);

        word_t   fetch_instr;
        logic    fetch_valid;
        uop_t    uop;
        issued_t issued;
        exec_t   exec_nxt;
        exec_t   exec_ff;
        wb_t     wb;
        logic    load_stall;
        logic    front_stall;

        // Fetch and decode also wait on a load-use hazard.
        assign front_stall = i_data_stall || load_stall;

        core_fetch u_core_fetch (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_stall        (front_stall),
                .i_instruction  (i_instruction),
                .i_valid        (i_valid),
                .o_pc           (o_pc),
                .o_instr        (fetch_instr),
                .o_instr_valid  (fetch_valid)
        );

        core_decode u_core_decode (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_stall        (front_stall),
                .i_instr        (fetch_instr),
                .i_instr_valid  (fetch_valid),
                .o_uop          (uop)
        );

        core_issue u_core_issue (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_data_stall   (i_data_stall),
                .i_uop          (uop),
                .i_exec_nxt     (exec_nxt),
                .i_exec_ff      (exec_ff),
                .i_wb           (wb),
                .o_load_stall   (load_stall),
                .o_issued       (issued)
        );

        core_execute u_core_execute (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_data_stall   (i_data_stall),
                .i_issued       (issued),
                .o_exec_nxt     (exec_nxt),
                .o_exec_ff      (exec_ff),
                .o_dmem         (o_dmem)
        );

        core_memory u_core_memory (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_data_stall   (i_data_stall),
                .i_exec         (exec_ff),
                .i_rd_data      (i_rd_data),
                .o_wb           (wb)
        );

endmodule
